// ==== hw/flash_params.svh ====
`ifndef FLASH_PARAMS_SVH
`define FLASH_PARAMS_SVH

//////////////////////////////
// Flash device timing
//////////////////////////////

// Wait cycles per half-word access.
`define FLASH_RW_BUS_CYCLE 3

//////////////////////////////
// Flash device widths
//////////////////////////////

// Half-word address.
`define FLASH_ADDR_W 22
// Data bus in word mode.
`define FLASH_DATA_W 16

`endif

// ==== hw/bus_pkg.sv ====
`default_nettype none

package bus_pkg;

  // Byte address on the system bus.
  typedef logic [23:0] bus_addr_t;
  typedef logic [31:0] bus_data_t;
  typedef logic [3:0]  bus_be_t;

  // Request held by the master until stall is low.
  typedef struct packed {
    bus_addr_t addr;
    bus_data_t wdata;
    bus_be_t   be;
    logic      read;
    logic      write;
  } bus_req_t;

endpackage

`default_nettype wire

// ==== hw/flash_pkg.sv ====
`default_nettype none

`include "flash_params.svh"

package flash_pkg;

  typedef logic [`FLASH_ADDR_W-1:0] flash_addr_t;
  typedef logic [`FLASH_DATA_W-1:0] flash_half_t;

  // One half-word device request.
  typedef struct packed {
    flash_addr_t addr;
    flash_half_t wdata;
    logic        read;
    logic        write;
  } dev_req_t;

  // Parallel interface FSM.
  typedef enum logic [1:0] {
    IDLE,
    ACTIVE,
    DONE
  } ifce_state_e;

endpackage

`default_nettype wire

// ==== hw/parallel_ifce.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "flash_params.svh"

module parallel_ifce import flash_pkg::*; #(
  parameter int unsigned RW_BUS_CYCLE = `FLASH_RW_BUS_CYCLE
) (
  input  wire         clk_bus,
  input  wire         rst_n,
  input  wire         dev_req_t dev_req_i,
  output flash_half_t dev_rdata_o,
  output logic        dev_stall_o,
  output flash_addr_t flash_addr_o,
  output logic        flash_ce_n_o,
  output logic        flash_oe_n_o,
  output logic        flash_we_n_o,
  inout  wire         flash_half_t flash_data_io
);

  localparam int unsigned CNT_W = $clog2(RW_BUS_CYCLE + 1);
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(RW_BUS_CYCLE);

  ifce_state_e      state_q;
  logic [CNT_W-1:0] cnt_q;
  flash_half_t      rdata_q;
  logic             req_present;
  logic             busy;
  logic             done;

  assign req_present = dev_req_i.read || dev_req_i.write;

  // Access runs from the first IDLE cycle with a request to the end of ACTIVE.
  assign busy = ((state_q == IDLE) && req_present) || (state_q == ACTIVE);
  assign done = (state_q == ACTIVE) && (cnt_q == CNT_LAST);

  // Also high in DONE, so a new request waits for IDLE.
  assign dev_stall_o = req_present && !done;

  //////////////////////////////
  // Access FSM
  //////////////////////////////

  always_ff @(posedge clk_bus or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
      cnt_q   <= '0;
    end else begin
      case (state_q)
        IDLE: begin
          if (req_present) begin
            state_q <= ACTIVE;
            cnt_q   <= CNT_W'(1);
          end
        end
        ACTIVE: begin
          if (done) begin
            state_q <= DONE;
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        // Chip enable off for one cycle.
        DONE: begin
          state_q <= IDLE;
        end
        default: begin
          state_q <= IDLE;
        end
      endcase
    end
  end

  // Last stalled cycle leaves the device data here.
  always_ff @(posedge clk_bus) begin
    if (busy && !done && dev_req_i.read) begin
      rdata_q <= flash_data_io;
    end
  end

  assign dev_rdata_o = rdata_q;

  //////////////////////////////
  // Device pins
  //////////////////////////////

  // Address and write data are held by the requester until completion.
  assign flash_addr_o = dev_req_i.addr;
  assign flash_ce_n_o = !busy;
  assign flash_oe_n_o = !(busy && dev_req_i.read);

  // WE rises in the completion cycle while data is still driven.
  assign flash_we_n_o = !(busy && !done && dev_req_i.write);

  assign flash_data_io = (busy && dev_req_i.write) ? dev_req_i.wdata : 'z;

endmodule

`default_nettype wire

// ==== hw/flash_word_split.sv ====
`timescale 1ns/100ps
`default_nettype none

module flash_word_split import bus_pkg::*, flash_pkg::*; (
  input  wire         clk_bus,
  input  wire         rst_n,
  input  wire         bus_req_t bus_req_i,
  input  wire         flash_half_t dev_rdata_i,
  input  wire         dev_stall_i,
  output bus_data_t   bus_data_o,
  output logic        bus_stall_o,
  output dev_req_t    dev_req_o
);

  typedef enum logic [1:0] {
    SPLIT_IDLE,
    SPLIT_LOWER,
    SPLIT_UPPER
  } split_state_e;

  split_state_e state_q;
  flash_half_t  lower_q;
  logic         word_read;
  logic         upper_half;

  assign word_read = bus_req_i.read && (&bus_req_i.be);

  // Second phase of a word read, or an access to the upper half only.
  assign upper_half = (state_q == SPLIT_UPPER) || !(|bus_req_i.be[1:0]);

  always_comb begin
    dev_req_o.addr  = {bus_req_i.addr[22:2], upper_half};
    dev_req_o.wdata = upper_half ? bus_req_i.wdata[31:16] : bus_req_i.wdata[15:0];
    dev_req_o.read  = bus_req_i.read;
    dev_req_o.write = bus_req_i.write;
  end

  //////////////////////////////
  // Word read sequencing
  //////////////////////////////

  always_ff @(posedge clk_bus or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= SPLIT_IDLE;
    end else begin
      case (state_q)
        // Lower half goes out in this same cycle.
        SPLIT_IDLE: begin
          if (word_read) begin
            state_q <= SPLIT_LOWER;
          end
        end
        SPLIT_LOWER: begin
          if (!dev_stall_i) begin
            state_q <= SPLIT_UPPER;
          end
        end
        SPLIT_UPPER: begin
          if (!dev_stall_i) begin
            state_q <= SPLIT_IDLE;
          end
        end
        default: begin
          state_q <= SPLIT_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk_bus) begin
    if ((state_q == SPLIT_LOWER) && !dev_stall_i) begin
      lower_q <= dev_rdata_i;
    end
  end

  // Lower phase completion is hidden from the master.
  assign bus_stall_o = dev_stall_i || (state_q == SPLIT_LOWER);

  assign bus_data_o = (state_q == SPLIT_UPPER) ? {dev_rdata_i, lower_q}
                                               : {2{dev_rdata_i}};

endmodule

`default_nettype wire

// ==== hw/flash_top.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "flash_params.svh"

module flash_top import bus_pkg::*, flash_pkg::*; (
  input  wire         clk_bus,
  input  wire         rst_n,
  input  wire         bus_req_t bus_req_i,
  output bus_data_t   bus_data_o,
  output logic        bus_stall_o,
  output flash_addr_t flash_addr_o,
  output logic        flash_we_n_o,
  output logic        flash_oe_n_o,
  output logic        flash_byte_n_o,
  output logic        flash_rp_n_o,
  output logic [2:0]  flash_ce_o,
  output logic        flash_vpen_o,
  inout  wire         flash_half_t flash_data_io
);

  dev_req_t    dev_req;
  flash_half_t dev_rdata;
  logic        dev_stall;

  flash_word_split split_i (
    .clk_bus     (clk_bus),
    .rst_n       (rst_n),
    .bus_req_i   (bus_req_i),
    .dev_rdata_i (dev_rdata),
    .dev_stall_i (dev_stall),
    .bus_data_o  (bus_data_o),
    .bus_stall_o (bus_stall_o),
    .dev_req_o   (dev_req)
  );

  parallel_ifce #(
    .RW_BUS_CYCLE (`FLASH_RW_BUS_CYCLE)
  ) ifce_i (
    .clk_bus       (clk_bus),
    .rst_n         (rst_n),
    .dev_req_i     (dev_req),
    .dev_rdata_o   (dev_rdata),
    .dev_stall_o   (dev_stall),
    .flash_addr_o  (flash_addr_o),
    .flash_ce_n_o  (),
    .flash_oe_n_o  (flash_oe_n_o),
    .flash_we_n_o  (flash_we_n_o),
    .flash_data_io (flash_data_io)
  );

  // Word mode, all chips selected, programming enabled.
  assign flash_rp_n_o   = rst_n;
  assign flash_byte_n_o = 1'b1;
  assign flash_ce_o     = 3'b000;
  assign flash_vpen_o   = 1'b1;

endmodule

`default_nettype wire

// ==== tests/flash_model.sv ====
`timescale 1ns/100ps
`default_nettype none

module flash_model import flash_pkg::*; (
  input  wire         flash_addr_t addr_i,
  input  wire         ce_n_i,
  input  wire         oe_n_i,
  input  wire         we_n_i,
  inout  wire         flash_half_t data_io
);

  localparam int unsigned DEPTH = 1 << $bits(flash_addr_t);

  flash_half_t mem [0:DEPTH-1];
  flash_half_t rd_data;
  int unsigned mem_version = 0;

  // Fill pattern mixes every address bit.
  function automatic flash_half_t fill_half(input flash_addr_t addr);
    return {addr[5:0], addr[21:12]} ^ addr[15:0] ^ 16'h9e37;
  endfunction

  initial begin
    for (int i = 0; i < DEPTH; i++) begin
      mem[i] = fill_half(flash_addr_t'(i));
    end
    mem_version = mem_version + 1;
  end

  // Data is latched on the rising edge of write enable.
  always @(posedge we_n_i) begin
    if (ce_n_i === 1'b0 && !$isunknown(addr_i) && !$isunknown(data_io)) begin
      mem[addr_i] = data_io;
      mem_version = mem_version + 1;
    end
  end

  always @(addr_i or mem_version) begin
    rd_data = mem[addr_i];
  end

  assign data_io = (!ce_n_i && !oe_n_i && we_n_i) ? rd_data : 'z;

endmodule

`default_nettype wire

// ==== tests/tb_flash_top.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "flash_params.svh"

module tb_flash_top import bus_pkg::*, flash_pkg::*; ();

  localparam int unsigned CLK_PERIOD = 20;
  localparam int unsigned WAIT_LIMIT = 200;
  localparam int unsigned DEPTH = 1 << `FLASH_ADDR_W;
  localparam int unsigned RW = `FLASH_RW_BUS_CYCLE;

  logic        clk_bus;
  logic        rst_n;
  bus_req_t    bus_req;
  bus_data_t   bus_data;
  logic        bus_stall;
  flash_addr_t flash_addr;
  logic        flash_we_n;
  logic        flash_oe_n;
  logic        flash_byte_n;
  logic        flash_rp_n;
  logic [2:0]  flash_ce;
  logic        flash_vpen;
  wire         flash_half_t flash_data;

  flash_half_t mirror [0:DEPTH-1];
  logic [31:0] lcg_state;
  int unsigned errors;
  int unsigned checks;
  int unsigned tests;
  logic        aborted;

  flash_top dut_i (
    .clk_bus        (clk_bus),
    .rst_n          (rst_n),
    .bus_req_i      (bus_req),
    .bus_data_o     (bus_data),
    .bus_stall_o    (bus_stall),
    .flash_addr_o   (flash_addr),
    .flash_we_n_o   (flash_we_n),
    .flash_oe_n_o   (flash_oe_n),
    .flash_byte_n_o (flash_byte_n),
    .flash_rp_n_o   (flash_rp_n),
    .flash_ce_o     (flash_ce),
    .flash_vpen_o   (flash_vpen),
    .flash_data_io  (flash_data)
  );

  flash_model model_i (
    .addr_i  (flash_addr),
    .ce_n_i  (flash_ce[0]),
    .oe_n_i  (flash_oe_n),
    .we_n_i  (flash_we_n),
    .data_io (flash_data)
  );

  initial begin
    clk_bus = 1'b0;
    forever #(CLK_PERIOD / 2) clk_bus = ~clk_bus;
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic flash_half_t fill_pattern(input flash_addr_t addr);
    return {addr[5:0], addr[21:12]} ^ addr[15:0] ^ 16'h9e37;
  endfunction

  // Byte address bits 22:2 select the word, the last bit the half.
  function automatic flash_addr_t half_addr(input bus_addr_t addr, input logic upper);
    return {addr[22:2], upper};
  endfunction

  function automatic bus_data_t expect_read(input bus_req_t req);
    flash_half_t lower;
    flash_half_t upper;
    lower = mirror[half_addr(req.addr, 1'b0)];
    upper = mirror[half_addr(req.addr, 1'b1)];
    if (&req.be) begin
      return {upper, lower};
    end
    return (req.be[1:0] == 2'b00) ? {2{upper}} : {2{lower}};
  endfunction

  // Any write narrower than the upper half alone lands in the lower half.
  task automatic mirror_write(input bus_req_t req);
    if (req.be[1:0] == 2'b00) begin
      mirror[half_addr(req.addr, 1'b1)] = req.wdata[31:16];
    end else begin
      mirror[half_addr(req.addr, 1'b0)] = req.wdata[15:0];
    end
  endtask

  function automatic bus_req_t make_req(input logic write, input bus_be_t be,
                                        input bus_addr_t addr);
    bus_req_t req;
    req = '0;
    req.addr  = addr;
    req.be    = be;
    req.read  = !write;
    req.write = write;
    if (write) begin
      req.wdata = lcg_next();
    end
    return req;
  endfunction

  task automatic compare(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
    if (!aborted) begin
      checks++;
      if (actual !== expected) begin
        errors++;
        $display("Mismatch at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
      end
    end
  endtask

  ////////////////////////////////
  // Bus handshake
  ////////////////////////////////

  // Request is held until a cycle with stall low.
  task automatic bus_access(input bus_req_t req, output bus_data_t rdata,
                            output flash_addr_t dev_addr,
                            output int unsigned stall_cycles);
    int unsigned cycles;
    cycles = 0;
    rdata = 'x;
    dev_addr = 'x;
    stall_cycles = 0;
    if (!aborted) begin
      @(negedge clk_bus);
      bus_req = req;
      #1;
      while (bus_stall && cycles < WAIT_LIMIT) begin
        @(negedge clk_bus);
        cycles++;
      end
      if (bus_stall) begin
        $display("Timeout: bus_stall_o did not fall within %0d cycles at %0t ns",
                 WAIT_LIMIT, $time);
        errors++;
        aborted = 1'b1;
      end else begin
        rdata = bus_data;
        dev_addr = flash_addr;
        stall_cycles = cycles;
      end
      @(posedge clk_bus);
    end
  endtask

  task automatic bus_idle();
    @(negedge clk_bus);
    bus_req = '0;
  endtask

  task automatic run_access(input bus_req_t req, output int unsigned stalls);
    bus_data_t   data;
    bus_data_t   expected;
    flash_addr_t addr;
    logic        upper;
    expected = expect_read(req);
    // A word read completes in its upper phase.
    upper = (req.be[1:0] == 2'b00) || (req.read && (&req.be));
    bus_access(req, data, addr, stalls);
    compare("flash_addr_o", addr, half_addr(req.addr, upper));
    if (req.read) begin
      compare("bus_data_o", data, expected);
    end else begin
      mirror_write(req);
    end
  endtask

  task automatic report_test(input string name, input int unsigned start_errors);
    tests++;
    $display("%s: %0d errors", name, errors - start_errors);
  endtask

  ////////////////////////////////
  // Tests
  ////////////////////////////////

  task automatic test_reset_state();
    int unsigned start_errors;
    start_errors = errors;
    rst_n = 1'b0;
    repeat (10) @(negedge clk_bus);
    compare("flash_rp_n_o", flash_rp_n, 1'b0);
    rst_n = 1'b1;
    @(negedge clk_bus);
    compare("flash_oe_n_o", flash_oe_n, 1'b1);
    compare("flash_we_n_o", flash_we_n, 1'b1);
    compare("bus_stall_o", bus_stall, 1'b0);
    compare("flash_data_io", flash_data, 16'hzzzz);
    compare("flash_rp_n_o", flash_rp_n, 1'b1);
    compare("flash_byte_n_o", flash_byte_n, 1'b1);
    compare("flash_ce_o", flash_ce, 3'b000);
    compare("flash_vpen_o", flash_vpen, 1'b1);
    report_test("reset_state", start_errors);
  endtask

  task automatic test_word_read();
    int unsigned start_errors;
    int unsigned stalls;
    start_errors = errors;
    repeat (4) begin
      run_access(make_req(1'b0, 4'b1111, bus_addr_t'(lcg_next())), stalls);
      // Two half accesses plus the hidden lower completion and the DONE cycle.
      compare("bus_stall_o cycles", stalls, 2 * RW + 2);
      bus_idle();
    end
    report_test("word_read", start_errors);
  endtask

  task automatic test_half_read();
    int unsigned start_errors;
    int unsigned stalls;
    start_errors = errors;
    repeat (3) begin
      run_access(make_req(1'b0, 4'b0011, bus_addr_t'(lcg_next())), stalls);
      compare("bus_stall_o cycles", stalls, RW);
      bus_idle();
      run_access(make_req(1'b0, 4'b1100, bus_addr_t'(lcg_next())), stalls);
      compare("bus_stall_o cycles", stalls, RW);
      bus_idle();
    end
    report_test("half_read", start_errors);
  endtask

  // Each write is read back as a word, so the untouched half is checked too.
  task automatic test_write(input string name, input bus_be_t be);
    int unsigned start_errors;
    int unsigned stalls;
    bus_addr_t   addr;
    start_errors = errors;
    repeat (3) begin
      addr = bus_addr_t'(lcg_next());
      run_access(make_req(1'b1, be, addr), stalls);
      bus_idle();
      run_access(make_req(1'b0, 4'b1111, addr), stalls);
      bus_idle();
    end
    report_test(name, start_errors);
  endtask

  task automatic test_mixed_traffic();
    int unsigned start_errors;
    int unsigned stalls;
    logic [31:0] r;
    bus_be_t     be;
    start_errors = errors;
    for (int i = 0; i < 60; i++) begin
      r = lcg_next();
      case (r[9:8] % 3)
        0: be = 4'b1111;
        1: be = 4'b0011;
        default: be = 4'b1100;
      endcase
      // Small window so reads hit earlier writes; bits 23 and 1:0 are ignored.
      run_access(make_req(r[12], be, bus_addr_t'(24'h3a_5000 | (r & 32'h80_001f))), stalls);
    end
    bus_idle();
    report_test("mixed_traffic", start_errors);
  endtask

  initial begin
    rst_n = 1'b0;
    bus_req = '0;
    lcg_state = 32'h6af0_6153;
    errors = 0;
    checks = 0;
    tests = 0;
    aborted = 1'b0;
    for (int i = 0; i < DEPTH; i++) begin
      mirror[i] = fill_pattern(flash_addr_t'(i));
    end

    test_reset_state();
    test_word_read();
    test_half_read();
    test_write("half_write_upper", 4'b1100);
    test_write("half_write_lower", 4'b0011);
    test_write("word_write", 4'b1111);
    test_mixed_traffic();

    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+hw
hw/bus_pkg.sv
hw/flash_pkg.sv
hw/parallel_ifce.sv
hw/flash_word_split.sv
hw/flash_top.sv
tests/flash_model.sv
tests/tb_flash_top.sv

// ==== Bender.yml ====
package:
  name: flash_bridge

sources:
  - include_dirs:
      - hw
    files:
      - hw/bus_pkg.sv
      - hw/flash_pkg.sv
      - hw/parallel_ifce.sv
      - hw/flash_word_split.sv
      - hw/flash_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - tests/flash_model.sv
      - tests/tb_flash_top.sv
